// ==== Bender.yml ====
package:
  name: hyper_todram

sources:
  - include_dirs:
      - hw
    files:
      - hw/hyper_lsab_pkg.sv
      - hw/hyper_dram_pkg.sv
      - hw/lsab_sections.sv
      - hw/mvblck_counter.sv
      - hw/mvblck_fsm.sv
      - hw/dram_word_collector.sv
      - hw/hyper_todram_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/hyper_todram_assertions.sv
      - bench/hyper_todram_tb.sv

// ==== bench/hyper_todram_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module hyper_todram_assertions
	import hyper_lsab_pkg::*;
	import hyper_dram_pkg::*;
(
	input wire           CLK,
	input wire           RST,
	input wire           issue,
	input wire           working,
	input wire           done,
	input lsab_section_t section,
	input item_addr_t    cur_addr,
	input mcu_write_t    mcu
);

	int unsigned fails = 0;

	done_single: assert property (@(posedge CLK) disable iff (!RST) done |=> !done)
	else
	begin
		$error("done stayed high for more than one cycle.");
		fails++;
	end

	// the last request of a move still falls inside the delayed busy window.
	idle_quiet: assert property (@(posedge CLK) disable iff (!RST)
		(!working && !$past(working)) |-> !mcu.request)
	else
	begin
		$error("write request while the mover was idle.");
		fails++;
	end

	we_nonzero: assert property (@(posedge CLK) disable iff (!RST) mcu.request |-> mcu.we != '0)
	else
	begin
		$error("write request without any byte enable.");
		fails++;
	end

	// a command taken during a move would switch the section or jump the address.
	busy_ignore: assert property (@(posedge CLK) disable iff (!RST)
		(issue && working) |=>
		($stable(section) && item_addr_t'(cur_addr - $past(cur_addr)) <= item_addr_t'(1)))
	else
	begin
		$error("command was loaded while a move was running.");
		fails++;
	end

endmodule

bind hyper_todram_top hyper_todram_assertions u_assert (
	.CLK      (CLK),
	.RST      (RST),
	.issue    (issue),
	.working  (working),
	.done     (done),
	.section  (section),
	.cur_addr (cur_addr),
	.mcu      (mcu)
);

`default_nettype wire

// ==== bench/hyper_todram_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hyper_defs.svh"

module hyper_todram_tb
	import hyper_lsab_pkg::*;
	import hyper_dram_pkg::*;
();

	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam int PERIOD = 4;

	logic          CLK = 1'b0;
	logic          RST;
	logic          lsab_write;
	lsab_section_t lsab_wsection;
	lsab_item_t    lsab_wdata;
	mover_cmd_t    cmd;
	logic          issue;
	logic          working;
	logic          done;
	item_count_t   count_sent;
	mcu_write_t    mcu;

	lsab_item_t  model_q [`HYPER_SECTIONS][$]; // items each section should still hold.
	lsab_item_t  sent_items [$];
	mcu_write_t  exp_q [$];
	mcu_write_t  seen_q [$];
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          done_pulses = 0;
	item_count_t sent_at_done;

	always #(PERIOD / 2) CLK = ~CLK;

	hyper_todram_top dut (
		.CLK           (CLK),
		.RST           (RST),
		.lsab_write    (lsab_write),
		.lsab_wsection (lsab_wsection),
		.lsab_wdata    (lsab_wdata),
		.cmd           (cmd),
		.issue         (issue),
		.working       (working),
		.done          (done),
		.count_sent    (count_sent),
		.mcu           (mcu)
	);

	// the MCU side accepts every request, so recording it is all the model needs.
	always @(negedge CLK)
	begin
		if (RST && mcu.request)
			seen_q.push_back(mcu);
		if (RST && done)
		begin
			done_pulses++;
			sent_at_done = count_sent; // only settled in the done cycle.
		end
	end

	function automatic int error_total();
		return errors + int'(dut.u_assert.fails);
	endfunction

	function automatic mover_cmd_t make_cmd(input item_addr_t addr, input item_count_t count,
		input lsab_section_t sec);
		mover_cmd_t c;
		c.start_addr = addr;
		c.count = count;
		c.section = sec;
		return c;
	endfunction

	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_event(input logic ok, input string what);
		assert (ok)
		else
		begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic fill_section(input lsab_section_t sec, input int n);
		lsab_item_t item;
		for (int i = 0; i < n; i++)
		begin
			item = lsab_item_t'($urandom);
			lsab_write = 1'b1;
			lsab_wsection = sec;
			lsab_wdata = item;
			if (model_q[sec].size() < `HYPER_LSAB_DEPTH)
				model_q[sec].push_back(item); // a full section drops the write.
			step();
		end
		lsab_write = 1'b0;
	endtask

	// Items pair up by DRAM word. A word with only one item present keeps
	// the enables of that half alone and zero data in the other half.
	task automatic build_expected(input item_addr_t start, input int n);
		mcu_write_t w;
		item_addr_t a;
		int i;
		exp_q.delete();
		i = 0;
		while (i < n)
		begin
			a = start + item_addr_t'(i);
			w.addr = {a[`HYPER_ADDR_W-1:1], 1'b0};
			w.request = 1'b1;
			if (a[0])
			begin
				w.data = {sent_items[i], 16'h0000};
				w.we = 4'b1100;
				i += 1;
			end
			else if (i + 1 < n)
			begin
				w.data = {sent_items[i+1], sent_items[i]};
				w.we = 4'b1111;
				i += 2;
			end
			else
			begin
				w.data = {16'h0000, sent_items[i]};
				w.we = 4'b0011;
				i += 1;
			end
			exp_q.push_back(w);
		end
	endtask

	task automatic run_move(input mover_cmd_t c, input logic busy_issue, input mover_cmd_t other);
		int n;
		int cycles;
		n = (int'(c.count) < model_q[c.section].size()) ? int'(c.count)
			: model_q[c.section].size();
		sent_items.delete();
		for (int i = 0; i < n; i++)
			sent_items.push_back(model_q[c.section].pop_front());
		build_expected(c.start_addr, n);
		seen_q.delete();
		done_pulses = 0;
		cmd = c;
		issue = 1'b1;
		step();
		issue = 1'b0;
		if (busy_issue)
		begin
			cycles = 0;
			while (!working && cycles < 10)
			begin
				step();
				cycles++;
			end
			check_event(working, "working did not rise after the command was issued");
			cmd = other; // must be ignored while the first move runs.
			issue = 1'b1;
			step();
			issue = 1'b0;
		end
		cycles = 0;
		while (done_pulses == 0 && cycles < 100)
		begin
			step();
			cycles++;
		end
		check_event(done_pulses != 0, "done did not arrive within 100 cycles");
		cycles = 0;
		while (working && cycles < 20)
		begin
			step();
			cycles++;
		end
		check_event(!working, "working stayed high after done");
		check_value("count_sent", sent_at_done, n);
		check_value("done pulses", done_pulses, 1);
		check_value("mcu request count", seen_q.size(), exp_q.size());
		foreach (exp_q[i])
		begin
			if (i < seen_q.size())
			begin
				check_value("mcu.addr", seen_q[i].addr, exp_q[i].addr);
				check_value("mcu.data", seen_q[i].data, exp_q[i].data);
				check_value("mcu.we", seen_q[i].we, exp_q[i].we);
			end
		end
	endtask

	task automatic report_test(input string name, input int mark);
		tests_run++;
		if (error_total() == mark)
			$display("%s: passed", name);
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, error_total() - mark);
		end
	endtask

	task automatic aligned_full_move();
		int mark;
		mark = error_total();
		check_value("working", working, 0); // still the values left by reset.
		check_value("done", done, 0);
		check_value("mcu.request", mcu.request, 0);
		check_value("mcu.we", mcu.we, 0);
		check_value("count_sent", count_sent, 0);
		fill_section(0, 8);
		run_move(make_cmd(12'h040, 8, 0), 1'b0, '0);
		report_test("aligned full move", mark);
	endtask

	task automatic odd_start_move();
		int mark;
		mark = error_total();
		fill_section(1, 6);
		run_move(make_cmd(12'h101, 6, 1), 1'b0, '0); // lone odd first, lone even last.
		report_test("odd start and odd end", mark);
	endtask

	task automatic section_runs_empty();
		int mark;
		mark = error_total();
		fill_section(2, 3);
		run_move(make_cmd(12'h300, 10, 2), 1'b0, '0);
		report_test("section runs empty", mark);
	endtask

	task automatic empty_at_start();
		int mark;
		mark = error_total();
		run_move(make_cmd(12'h010, 7, 3), 1'b0, '0);
		report_test("empty at start", mark);
	endtask

	task automatic section_isolation();
		int mark;
		mark = error_total();
		for (int i = 0; i < 12; i++)
			fill_section(lsab_section_t'($urandom), 1);
		for (int i = 0; i < 6; i++)
			run_move(make_cmd(item_addr_t'($urandom), item_count_t'($urandom_range(1, 6)),
				lsab_section_t'($urandom)), 1'b0, '0);
		// whatever is left must still come out in order.
		for (int s = 0; s < `HYPER_SECTIONS; s++)
			run_move(make_cmd(item_addr_t'($urandom), 20, lsab_section_t'(s)), 1'b0, '0);
		report_test("section isolation", mark);
	endtask

	task automatic issue_while_busy();
		int mark;
		mark = error_total();
		fill_section(0, 8);
		fill_section(1, 3);
		run_move(make_cmd(12'h080, 8, 0), 1'b1, make_cmd(12'h0c1, 3, 1));
		run_move(make_cmd(12'h0c1, 3, 1), 1'b0, '0); // section 1 was left alone.
		report_test("issue while busy", mark);
	endtask

	initial
	begin
		void'($urandom(32'hc23c_0f68));
		RST = 1'b0;
		lsab_write = 1'b0;
		lsab_wsection = '0;
		lsab_wdata = '0;
		cmd = '0;
		issue = 1'b0;
		repeat (2) @(posedge CLK);
		#1;
		RST = 1'b1;
		aligned_full_move();
		odd_start_move();
		section_runs_empty();
		empty_at_start();
		section_isolation();
		issue_while_busy();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			error_total());
		if (error_total() == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * PERIOD);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/dram_word_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_word_collector
	import hyper_lsab_pkg::*;
	import hyper_dram_pkg::*;
(
	input  wire        CLK,
	input  wire        RST,
	input  wire        pop,
	input  item_addr_t cur_addr,
	input  lsab_item_t rd_item,
	input  wire        flush,
	output mcu_write_t mcu
);

	logic       pop_d;      // rd_item holds a fresh item this cycle.
	item_addr_t addr_d;     // address of that item.
	logic       even_valid;
	lsab_item_t even_data;
	item_addr_t even_addr;
	item_addr_t word_addr;
	logic       take_odd;
	logic       take_even;
	logic       flush_even;

	logic                     req_q;
	dram_we_t                 we_q;
	item_addr_t               addr_q;
	logic [$bits(mcu.data)-1:0] data_q;

	assign word_addr = {addr_d[$bits(item_addr_t)-1:1], 1'b0};

	assign take_odd = pop_d && addr_d[0];
	assign take_even = pop_d && !addr_d[0];
	// a lone even half is only written out when the move ends.
	assign flush_even = flush && even_valid;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			pop_d <= 1'b0;
			even_valid <= 1'b0;
			req_q <= 1'b0;
			we_q <= '0;
		end
		else
		begin
			pop_d <= pop;
			req_q <= take_odd || flush_even;
			if (take_odd)
			begin
				// the even half is missing when the move started on an odd address.
				we_q <= {2'b11, {2{even_valid}}};
				even_valid <= 1'b0;
			end
			else if (take_even)
			begin
				we_q <= '0;
				even_valid <= 1'b1;
			end
			else if (flush_even)
			begin
				we_q <= 4'b0011;
				even_valid <= 1'b0;
			end
			else
				we_q <= '0;
		end
	end

	always_ff @(posedge CLK)
	begin
		addr_d <= cur_addr;
		if (take_even)
		begin
			even_data <= rd_item;
			even_addr <= word_addr;
		end
		if (take_odd)
		begin
			addr_q <= word_addr;
			data_q <= {rd_item, even_valid ? even_data : lsab_item_t'(0)};
		end
		else if (flush_even)
		begin
			addr_q <= even_addr;
			data_q <= {lsab_item_t'(0), even_data};
		end
	end

	assign mcu = '{addr: addr_q, data: data_q, we: we_q, request: req_q};

endmodule

`default_nettype wire

// ==== hw/hyper_defs.svh ====
`ifndef HYPER_DEFS_SVH
`define HYPER_DEFS_SVH

// width of one item held in the load/store buffer.
`define HYPER_ITEM_W 16

// item addresses count 16-bit items, so bit 0 picks a half of a DRAM word.
`define HYPER_ADDR_W 12

// number of items one command may ask for.
`define HYPER_COUNT_W 6

// the LSAB is split into this many independent sections.
`define HYPER_SECTIONS 4

// items per section. Keep this a power of two so the
// section pointers wrap on their own.
`define HYPER_LSAB_DEPTH 16

// width of one DRAM word on the MCU write port.
`define HYPER_WORD_W 32

`endif

// ==== hw/hyper_dram_pkg.sv ====
`default_nettype none

`include "hyper_defs.svh"

package hyper_dram_pkg;

	import hyper_lsab_pkg::*;

	typedef logic [`HYPER_ADDR_W-1:0] item_addr_t; // bit 0 selects the half word.
	typedef logic [`HYPER_COUNT_W-1:0] item_count_t;

	// bits 1:0 enable the even item, bits 3:2 the odd item.
	typedef logic [`HYPER_WORD_W/8-1:0] dram_we_t;

	// one block move as handed to the mover.
	typedef struct packed {
		item_addr_t    start_addr;
		item_count_t   count;
		lsab_section_t section;
	} mover_cmd_t;

	// write request towards the MCU.
	// The address is word aligned, so bit 0 is always zero.
	typedef struct packed {
		item_addr_t               addr;
		logic [`HYPER_WORD_W-1:0] data;
		dram_we_t                 we;
		logic                     request;
	} mcu_write_t;

	typedef enum logic [1:0] {
		IDLE,
		MOVE,
		FLUSH
	} mover_state_t;

endpackage

`default_nettype wire

// ==== hw/hyper_lsab_pkg.sv ====
`default_nettype none

`include "hyper_defs.svh"

package hyper_lsab_pkg;

	// selects one of the LSAB sections.
	typedef logic [$clog2(`HYPER_SECTIONS)-1:0] lsab_section_t;

	typedef logic [`HYPER_ITEM_W-1:0] lsab_item_t; // one buffered item.

	// one empty flag per section, bit i belongs to section i.
	typedef logic [`HYPER_SECTIONS-1:0] lsab_status_t;

endpackage

`default_nettype wire

// ==== hw/hyper_todram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hyper_todram_top
	import hyper_lsab_pkg::*;
	import hyper_dram_pkg::*;
(
	input  wire           CLK,
	input  wire           RST,
	input  wire           lsab_write,
	input  lsab_section_t lsab_wsection,
	input  lsab_item_t    lsab_wdata,
	input  mover_cmd_t    cmd,
	input  wire           issue,
	output logic          working,
	output logic          done,
	output item_count_t   count_sent,
	output mcu_write_t    mcu
);

	logic          load;
	logic          pop;
	logic          flush;
	logic          left_zero;
	item_addr_t    cur_addr;
	lsab_section_t section;
	lsab_status_t  status;
	lsab_item_t    rd_item;

	lsab_sections u_lsab (
		.CLK           (CLK),
		.RST           (RST),
		.lsab_write    (lsab_write),
		.lsab_wsection (lsab_wsection),
		.lsab_wdata    (lsab_wdata),
		.pop           (pop),
		.rd_section    (section),
		.status        (status),
		.rd_item       (rd_item)
	);

	mvblck_counter u_counter (
		.CLK        (CLK),
		.RST        (RST),
		.load       (load),
		.cmd        (cmd),
		.pop        (pop),
		.cur_addr   (cur_addr),
		.left_zero  (left_zero),
		.count_sent (count_sent),
		.section    (section)
	);

	mvblck_fsm u_fsm (
		.CLK       (CLK),
		.RST       (RST),
		.issue     (issue),
		.status    (status),
		.section   (section),
		.left_zero (left_zero),
		.load      (load),
		.pop       (pop),
		.flush     (flush),
		.done      (done),
		.working   (working)
	);

	// the collector sees the address before the counter steps past it.
	dram_word_collector u_collector (
		.CLK      (CLK),
		.RST      (RST),
		.pop      (pop),
		.cur_addr (cur_addr),
		.rd_item  (rd_item),
		.flush    (flush),
		.mcu      (mcu)
	);

endmodule

`default_nettype wire

// ==== hw/lsab_sections.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hyper_defs.svh"

module lsab_sections
	import hyper_lsab_pkg::*;
(
	input  wire           CLK,
	input  wire           RST,
	input  wire           lsab_write,
	input  lsab_section_t lsab_wsection,
	input  lsab_item_t    lsab_wdata,
	input  wire           pop,
	input  lsab_section_t rd_section,
	output lsab_status_t  status,
	output lsab_item_t    rd_item
);

	localparam int PTR_W = $clog2(`HYPER_LSAB_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [PTR_W:0] level_t; // one extra bit so a full section fits.

	lsab_item_t mem [`HYPER_SECTIONS][`HYPER_LSAB_DEPTH];
	ptr_t       wr_ptr [`HYPER_SECTIONS];
	ptr_t       rd_ptr [`HYPER_SECTIONS];
	level_t     level [`HYPER_SECTIONS];

	logic [`HYPER_SECTIONS-1:0] full;
	logic [`HYPER_SECTIONS-1:0] wr_hit;
	logic [`HYPER_SECTIONS-1:0] rd_hit;
	logic                       wr_ok;
	logic                       rd_ok;

	always_comb
	begin
		for (int i = 0; i < `HYPER_SECTIONS; i++)
		begin
			status[i] = (level[i] == '0);
			full[i] = (level[i] == `HYPER_LSAB_DEPTH);
		end
	end

	// writes into a full section and pops from an empty one are dropped here.
	assign wr_ok = lsab_write && !full[lsab_wsection];
	assign rd_ok = pop && !status[rd_section];

	always_comb
	begin
		for (int i = 0; i < `HYPER_SECTIONS; i++)
		begin
			wr_hit[i] = wr_ok && (lsab_wsection == lsab_section_t'(i));
			rd_hit[i] = rd_ok && (rd_section == lsab_section_t'(i));
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			for (int i = 0; i < `HYPER_SECTIONS; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				level[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < `HYPER_SECTIONS; i++)
			begin
				if (wr_hit[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1; // wraps at the section depth.
				if (rd_hit[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				// a write and a pop on the same section cancel out.
				level[i] <= level[i] + level_t'(wr_hit[i]) - level_t'(rd_hit[i]);
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (wr_ok)
			mem[lsab_wsection][wr_ptr[lsab_wsection]] <= lsab_wdata;
		if (rd_ok)
			rd_item <= mem[rd_section][rd_ptr[rd_section]]; // valid the cycle after pop.
	end

endmodule

`default_nettype wire

// ==== hw/mvblck_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mvblck_counter
	import hyper_lsab_pkg::*;
	import hyper_dram_pkg::*;
(
	input  wire           CLK,
	input  wire           RST,
	input  wire           load,
	input  mover_cmd_t    cmd,
	input  wire           pop,
	output item_addr_t    cur_addr,
	output logic          left_zero,
	output item_count_t   count_sent,
	output lsab_section_t section
);

	item_addr_t    addr_q;
	item_count_t   req_q;   // count as it was requested.
	item_count_t   left_q;  // items still to be popped.
	lsab_section_t section_q;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			addr_q <= '0;
			req_q <= '0;
			left_q <= '0;
			section_q <= '0;
		end
		else if (load)
		begin
			addr_q <= cmd.start_addr;
			req_q <= cmd.count;
			left_q <= cmd.count;
			section_q <= cmd.section;
		end
		else if (pop)
		begin
			addr_q <= addr_q + 1'b1;
			left_q <= left_q - 1'b1;
		end
	end

	assign cur_addr = addr_q; // address of the item the next pop returns.
	assign section = section_q;
	assign left_zero = (left_q == '0);

	// The difference only settles once the FSM has stopped popping,
	// which is the FLUSH cycle.
	assign count_sent = req_q - left_q;

endmodule

`default_nettype wire

// ==== hw/mvblck_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module mvblck_fsm
	import hyper_lsab_pkg::*;
	import hyper_dram_pkg::*;
(
	input  wire           CLK,
	input  wire           RST,
	input  wire           issue,
	input  lsab_status_t  status,
	input  lsab_section_t section,
	input  wire           left_zero,
	output logic          load,
	output logic          pop,
	output logic          flush,
	output logic          done,
	output logic          working
);

	mover_state_t state_q;
	mover_state_t state_d;
	logic         can_pop;
	logic         working_q;

	// the section picked by the command still has items and the count is not used up.
	assign can_pop = !status[section] && !left_zero;

	// A command is taken only once the delayed busy flag has dropped,
	// so the cycle right after a move ends still ignores issue.
	assign load = issue && (state_q == IDLE) && !working_q;
	assign pop = (state_q == MOVE) && can_pop;
	assign flush = (state_q == FLUSH);
	assign done = (state_q == FLUSH); // one cycle, since FLUSH always returns to IDLE.

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
			begin
				if (load)
					state_d = MOVE;
			end
			MOVE:
			begin
				// an empty section at the start lands here on the first cycle.
				if (!can_pop)
					state_d = FLUSH;
			end
			FLUSH:
				state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state_q <= IDLE;
			working_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// busy lags the state by a cycle to keep the driver off the MCU port.
			working_q <= (state_q != IDLE);
		end
	end

	assign working = working_q;

endmodule

`default_nettype wire

// ==== hyper_todram.f ====
+incdir+hw
hw/hyper_lsab_pkg.sv
hw/hyper_dram_pkg.sv
hw/lsab_sections.sv
hw/mvblck_counter.sv
hw/mvblck_fsm.sv
hw/dram_word_collector.sv
hw/hyper_todram_top.sv
bench/hyper_todram_assertions.sv
bench/hyper_todram_tb.sv
